// File: build.f
verilog/vdp_pkg.sv
verilog/vdp_host_regs.sv
verilog/vdp_layer_mask_gen.sv
verilog/vdp_layer_priority_select.sv
verilog/vdp_palette_lookup.sv
verilog/vdp_compositor.sv
verification/vdp_compositor_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := vdp_compositor_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/vdp_compositor_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vdp compositor testbench
// random pixels and palette contents checked against
// a reference model, Wishbone host driver, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module vdp_compositor_tb
    import vdp_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int COLOR_W      = 16;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_BURSTS     = 16;
    localparam int BURST_MAX    = 40;
    localparam int PAL_REWRITE  = 8;
    // a bus access takes three clocks, drains and gaps are bounded by 16 per burst
    localparam int BUS_CYCLES   = 3 * (16 + 256 + N_BURSTS * (1 + PAL_REWRITE));
    localparam int PIXEL_CYCLES = 32 + 64 + N_BURSTS * (BURST_MAX + 16);
    localparam int LIMIT_CYCLES = RESET_CYCLES + BUS_CYCLES + PIXEL_CYCLES + 200;

    logic                clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [COLOR_W-1:0]  wb_dat_w;
    logic [COLOR_W-1:0]  wb_dat_r;
    logic                wb_ack;
    logic                pixel_valid;
    logic [PIXEL_W-1:0]  scroll0_pixel;
    logic [PIXEL_W-1:0]  scroll1_pixel;
    logic [PIXEL_W-1:0]  scroll2_pixel;
    logic [PIXEL_W-1:0]  scroll3_pixel;
    logic [PIXEL_W-1:0]  sprite_pixel;
    logic [1:0]          sprite_priority;
    logic                color_valid;
    logic [COLOR_W-1:0]  color;
    logic [LAYER_W-1:0]  color_layer;
    logic [SCORE_W-1:0]  color_priority;

    // reference model state
    logic [31:0]         lcg_state;
    logic [LAYER_W-1:0]  enable_model;
    logic [COLOR_W-1:0]  palette_model [256];
    logic [COLOR_W-1:0]  exp_color [$];
    logic [LAYER_W-1:0]  exp_layer [$];
    logic [SCORE_W-1:0]  exp_score [$];
    int unsigned         exp_cycle [$];
    int unsigned         cycle_count = 0;
    int                  sprite_over_scroll = 0;
    int                  scroll_over_sprite = 0;
    int                  scroll_over_scroll = 0;

    vdp_compositor #(
        .COLOR_W (COLOR_W)
    ) dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Test failed");
        $fatal(1, "watchdog expired after %0d clock cycles, the run is stuck", LIMIT_CYCLES);
    end

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic int rand_below(input int n);
        logic [15:0] r;
        r = next_rand();
        return int'(r) % n;
    endfunction

    // colour 0 of each sub-palette is see-through, force it now and then
    function automatic logic [PIXEL_W-1:0] rand_pixel(input bit see_through);
        logic [15:0] r;
        r = next_rand();
        if (see_through || r[15:14] == 2'b00) begin
            return {r[7:4], 4'h0};
        end
        return r[7:0];
    endfunction

    task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                              input logic [COLOR_W-1:0] wdata,
                              output logic [COLOR_W-1:0] rdata);
        int waited;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 16) begin
                $display("Test failed");
                $fatal(1, "no wb_ack came within 16 cycles of the strobe");
            end
        end while (!wb_ack);
        check_equal("wb_ack latency", 32'(waited), 32'd1);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #2;
        check_equal("wb_ack one cycle later", 32'(wb_ack), 32'd0);
    endtask

    task automatic write_enable(input logic [COLOR_W-1:0] value);
        logic [COLOR_W-1:0] discard;
        bus_access(1'b1, WB_ADR_W'(REG_LAYER_ENABLE), value, discard);
        enable_model = value[LAYER_W-1:0];
    endtask

    task automatic write_palette(input logic [PIXEL_W-1:0] index,
                                 input logic [COLOR_W-1:0] value);
        logic [COLOR_W-1:0] discard;
        bus_access(1'b1, {1'b1, index}, value, discard);
        palette_model[index] = value;
    endtask

    task automatic read_expect(input logic [WB_ADR_W-1:0] adr,
                               input logic [COLOR_W-1:0] expected);
        logic [COLOR_W-1:0] data;
        bus_access(1'b0, adr, '0, data);
        check_equal("wb_dat_r", 32'(data), 32'(expected));
    endtask

    // topmost opaque layer wins, scroll0 in front, sprite on a strictly higher score
    task automatic push_expected();
        logic [PIXEL_W-1:0] layer_px [NUM_SCROLL];
        logic [PIXEL_W-1:0] index;
        logic [LAYER_W-1:0] code;
        int                 top;
        int                 opaque_count;
        int                 scroll_score;
        int                 sprite_score;
        int                 score;
        bit                 sprite_on;
        layer_px[0]  = scroll0_pixel;
        layer_px[1]  = scroll1_pixel;
        layer_px[2]  = scroll2_pixel;
        layer_px[3]  = scroll3_pixel;
        top          = -1;
        opaque_count = 0;
        for (int k = 0; k < NUM_SCROLL; k++) begin
            if (enable_model[k] && layer_px[k][3:0] != 4'h0) begin
                opaque_count++;
                if (top < 0) begin
                    top = k;
                end
            end
        end
        scroll_score = (top < 0) ? -1 : 2 * (NUM_SCROLL - 1 - top);
        sprite_score = 2 * int'(sprite_priority) + 1;
        sprite_on    = enable_model[LAYER_SPRITES] && (sprite_pixel[3:0] != 4'h0);
        if (sprite_on && sprite_score > scroll_score) begin
            index = sprite_pixel;
            code  = LAYER_W'(1) << LAYER_SPRITES;
            score = sprite_score;
            if (top >= 0) begin
                sprite_over_scroll++;
            end
        end else if (top >= 0) begin
            index = layer_px[top];
            code  = LAYER_W'(1) << top;
            score = scroll_score;
            if (sprite_on) begin
                scroll_over_sprite++;
            end
            if (opaque_count > 1) begin
                scroll_over_scroll++;
            end
        end else begin
            // backdrop
            index = '0;
            code  = '0;
            score = 0;
        end
        exp_color.push_back(palette_model[index]);
        exp_layer.push_back(code);
        exp_score.push_back(SCORE_W'(score));
        exp_cycle.push_back(cycle_count);
    endtask

    task automatic send_pixel(input bit see_through);
        logic [15:0] r;
        @(posedge clk);
        #2;
        pixel_valid     = 1'b1;
        scroll0_pixel   = rand_pixel(see_through);
        scroll1_pixel   = rand_pixel(see_through);
        scroll2_pixel   = rand_pixel(see_through);
        scroll3_pixel   = rand_pixel(see_through);
        sprite_pixel    = rand_pixel(see_through);
        r               = next_rand();
        sprite_priority = r[9:8];
        push_expected();
    endtask

    task automatic send_gap();
        logic [15:0] r;
        @(posedge clk);
        #2;
        r             = next_rand();
        pixel_valid   = 1'b0;
        // payload in a gap is don't care
        scroll0_pixel = r[7:0];
        sprite_pixel  = r[15:8];
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (exp_cycle.size() != 0) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 8) begin
                $display("Test failed");
                $fatal(1, "the pixel pipeline did not drain within 8 cycles");
            end
        end
    endtask

    // results come back in order, three cycles after their pixel went in
    always @(posedge clk) begin
        #1;
        cycle_count++;
        if (rst_n) begin
            if (exp_cycle.size() != 0 && cycle_count - exp_cycle[0] == 3) begin
                check_equal("color_valid for a due pixel", 32'(color_valid), 32'd1);
                check_equal("color", 32'(color), 32'(exp_color[0]));
                check_equal("color_layer", 32'(color_layer), 32'(exp_layer[0]));
                check_equal("color_priority", 32'(color_priority), 32'(exp_score[0]));
                void'(exp_color.pop_front());
                void'(exp_layer.pop_front());
                void'(exp_score.pop_front());
                void'(exp_cycle.pop_front());
            end else begin
                check_equal("color_valid with no pixel due", 32'(color_valid), 32'd0);
            end
        end
    end

    initial begin
        logic [COLOR_W-1:0] value;
        int                 len;
        lcg_state       = 32'd43;
        enable_model    = '1;
        rst_n           = 1'b0;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        pixel_valid     = 1'b0;
        scroll0_pixel   = '0;
        scroll1_pixel   = '0;
        scroll2_pixel   = '0;
        scroll3_pixel   = '0;
        sprite_pixel    = '0;
        sprite_priority = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // register map after reset
        check_equal("color_valid after reset", 32'(color_valid), 32'd0);
        check_equal("wb_ack after reset", 32'(wb_ack), 32'd0);
        read_expect(WB_ADR_W'(REG_LAYER_ENABLE), COLOR_W'({LAYER_W{1'b1}}));
        value = COLOR_W'(next_rand());
        write_enable(value);
        read_expect(WB_ADR_W'(REG_LAYER_ENABLE), COLOR_W'(value[LAYER_W-1:0]));
        read_expect(9'h001, '0);
        read_expect(9'h0a5, '0);
        read_expect(9'h100, '0);
        read_expect(9'h1ff, '0);
        write_enable(COLOR_W'({LAYER_W{1'b1}}));

        for (int i = 0; i < 256; i++) begin
            write_palette(PIXEL_W'(i), COLOR_W'(next_rand()));
        end

        // see-through everywhere shows the backdrop
        repeat (32) send_pixel(1'b1);
        send_gap();
        drain_pipeline();

        repeat (64) send_pixel(1'b0);
        send_gap();
        drain_pipeline();

        for (int b = 0; b < N_BURSTS; b++) begin
            write_enable(COLOR_W'(next_rand()));
            // palette rewrite waits until no pixel is in flight
            drain_pipeline();
            for (int i = 0; i < PAL_REWRITE; i++) begin
                write_palette(PIXEL_W'(next_rand()), COLOR_W'(next_rand()));
            end
            len = 1 + rand_below(BURST_MAX);
            for (int i = 0; i < len; i++) begin
                if (rand_below(4) == 0) begin
                    send_gap();
                end else begin
                    send_pixel(1'b0);
                end
            end
            send_gap();
        end
        drain_pipeline();

        check_equal("sprite over scroll seen", 32'(sprite_over_scroll > 0), 32'd1);
        check_equal("scroll over sprite seen", 32'(scroll_over_sprite > 0), 32'd1);
        check_equal("scroll over scroll seen", 32'(scroll_over_scroll > 0), 32'd1);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verilog/vdp_compositor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vdp compositor top level
// host slave plus the three stage pixel pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module vdp_compositor
    import vdp_pkg::*;
#(
    parameter int COLOR_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,

    // Wishbone classic slave
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [COLOR_W-1:0]  wb_dat_w,
    output logic [COLOR_W-1:0]  wb_dat_r,
    output logic                wb_ack,

    // one pixel from every layer each clock
    input  logic                pixel_valid,
    input  logic [PIXEL_W-1:0]  scroll0_pixel,
    input  logic [PIXEL_W-1:0]  scroll1_pixel,
    input  logic [PIXEL_W-1:0]  scroll2_pixel,
    input  logic [PIXEL_W-1:0]  scroll3_pixel,
    input  logic [PIXEL_W-1:0]  sprite_pixel,
    input  logic [1:0]          sprite_priority,

    output logic                color_valid,
    output logic [COLOR_W-1:0]  color,
    output logic [LAYER_W-1:0]  color_layer,
    output logic [SCORE_W-1:0]  color_priority
);

    logic [LAYER_W-1:0]     layer_enable;
    logic                   pal_we;
    logic [PALETTE_SEL-1:0] pal_addr;
    logic [COLOR_W-1:0]     pal_data;

    logic                   stage1_valid;
    logic [LAYER_W-1:0]     layer_mask;
    logic [PIXEL_W-1:0]     scroll0_r;
    logic [PIXEL_W-1:0]     scroll1_r;
    logic [PIXEL_W-1:0]     scroll2_r;
    logic [PIXEL_W-1:0]     scroll3_r;
    logic [PIXEL_W-1:0]     sprite_r;
    logic [1:0]             sprite_priority_r;

    logic                   stage2_valid;
    logic [LAYER_W-1:0]     prio_layer;
    logic [PIXEL_W-1:0]     prio_pixel;
    logic [SCORE_W-1:0]     prio_score;

    vdp_host_regs #(
        .COLOR_W (COLOR_W)
    ) u_host_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .layer_enable (layer_enable),
        .pal_we       (pal_we),
        .pal_addr     (pal_addr),
        .pal_data     (pal_data)
    );

    // stage 1, opaque mask
    vdp_layer_mask_gen u_mask_gen (
        .clk               (clk),
        .rst_n             (rst_n),
        .pixel_valid       (pixel_valid),
        .layer_enable      (layer_enable),
        .scroll0_pixel     (scroll0_pixel),
        .scroll1_pixel     (scroll1_pixel),
        .scroll2_pixel     (scroll2_pixel),
        .scroll3_pixel     (scroll3_pixel),
        .sprite_pixel      (sprite_pixel),
        .sprite_priority   (sprite_priority),
        .stage1_valid      (stage1_valid),
        .layer_mask        (layer_mask),
        .scroll0_r         (scroll0_r),
        .scroll1_r         (scroll1_r),
        .scroll2_r         (scroll2_r),
        .scroll3_r         (scroll3_r),
        .sprite_r          (sprite_r),
        .sprite_priority_r (sprite_priority_r)
    );

    // stage 2, topmost layer
    vdp_layer_priority_select u_priority_select (
        .clk               (clk),
        .rst_n             (rst_n),
        .stage1_valid      (stage1_valid),
        .layer_mask        (layer_mask),
        .scroll0_r         (scroll0_r),
        .scroll1_r         (scroll1_r),
        .scroll2_r         (scroll2_r),
        .scroll3_r         (scroll3_r),
        .sprite_r          (sprite_r),
        .sprite_priority_r (sprite_priority_r),
        .stage2_valid      (stage2_valid),
        .prio_layer        (prio_layer),
        .prio_pixel        (prio_pixel),
        .prio_score        (prio_score)
    );

    // stage 3, colour lookup
    vdp_palette_lookup #(
        .COLOR_W (COLOR_W)
    ) u_palette_lookup (
        .clk            (clk),
        .rst_n          (rst_n),
        .pal_we         (pal_we),
        .pal_addr       (pal_addr),
        .pal_data       (pal_data),
        .stage2_valid   (stage2_valid),
        .prio_layer     (prio_layer),
        .prio_pixel     (prio_pixel),
        .prio_score     (prio_score),
        .color_valid    (color_valid),
        .color          (color),
        .color_layer    (color_layer),
        .color_priority (color_priority)
    );

endmodule

// File: verilog/vdp_palette_lookup.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vdp palette lookup stage
// 256-entry colour RAM, host written, with a
// registered read per pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module vdp_palette_lookup
    import vdp_pkg::*;
#(
    parameter int COLOR_W = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // host write port
    input  logic                  pal_we,
    input  logic [WB_ADR_W-2:0]   pal_addr,
    input  logic [COLOR_W-1:0]    pal_data,

    input  logic                  stage2_valid,
    input  logic [LAYER_W-1:0]    prio_layer,
    input  logic [PIXEL_W-1:0]    prio_pixel,
    input  logic [SCORE_W-1:0]    prio_score,

    output logic                  color_valid,
    output logic [COLOR_W-1:0]    color,
    output logic [LAYER_W-1:0]    color_layer,
    output logic [SCORE_W-1:0]    color_priority
);

    // one entry per palette index
    localparam int PAL_DEPTH = 2 ** PIXEL_W;

    logic [COLOR_W-1:0] palette [PAL_DEPTH];

    // host write and pixel read share the clock
    // a pixel read on the write edge still sees the old colour
    always_ff @(posedge clk) begin
        if (pal_we) begin
            palette[pal_addr] <= pal_data;
        end
        color <= palette[prio_pixel];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            color_valid <= 1'b0;
        end else begin
            color_valid <= stage2_valid;
        end
    end

    // layer code and score follow the RAM read by one cycle
    always_ff @(posedge clk) begin
        color_layer    <= prio_layer;
        color_priority <= prio_score;
    end

endmodule

// File: verilog/vdp_layer_priority_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vdp layer priority stage
// picks the topmost opaque layer and registers its
// one-hot code, palette index and priority score
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module vdp_layer_priority_select
    import vdp_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,

    input  logic               stage1_valid,
    input  logic [LAYER_W-1:0] layer_mask,
    input  logic [PIXEL_W-1:0] scroll0_r,
    input  logic [PIXEL_W-1:0] scroll1_r,
    input  logic [PIXEL_W-1:0] scroll2_r,
    input  logic [PIXEL_W-1:0] scroll3_r,
    input  logic [PIXEL_W-1:0] sprite_r,
    input  logic [1:0]         sprite_priority_r,

    output logic               stage2_valid,
    output logic [LAYER_W-1:0] prio_layer,
    output logic [PIXEL_W-1:0] prio_pixel,
    output logic [SCORE_W-1:0] prio_score
);

    // one-hot code of each scroll layer, scroll0 first
    localparam logic [LAYER_W-1:0] SCROLL_OHE [NUM_SCROLL] = '{
        LAYER_SCROLL0_OHE,
        LAYER_SCROLL1_OHE,
        LAYER_SCROLL2_OHE,
        LAYER_SCROLL3_OHE
    };

    logic [PIXEL_W-1:0] scroll_px [NUM_SCROLL];

    logic               sprite_opaque;
    logic [SCORE_W-1:0] sprite_score;
    logic [SCORE_W-1:0] scroll_score;
    logic [LAYER_W-1:0] scroll_layer;
    logic [PIXEL_W-1:0] scroll_pixel;

    logic [LAYER_W-1:0] layer_next;
    logic [PIXEL_W-1:0] pixel_next;
    logic [SCORE_W-1:0] score_next;

    assign scroll_px[0] = scroll0_r;
    assign scroll_px[1] = scroll1_r;
    assign scroll_px[2] = scroll2_r;
    assign scroll_px[3] = scroll3_r;

    assign sprite_opaque = layer_mask[LAYER_SPRITES];

    // odd sprite scores sit between the even scroll scores
    assign sprite_score = {sprite_priority_r, 1'b1};

    // walk from the bottom layer up so the top opaque one overrides
    // with nothing opaque the zero defaults select the backdrop
    always_comb begin
        scroll_score = '0;
        scroll_layer = '0;
        scroll_pixel = '0;
        for (int i = NUM_SCROLL - 1; i >= 0; i--) begin
            if (layer_mask[LAYER_SCROLL0 + i]) begin
                scroll_score = {2'(NUM_SCROLL - 1 - i), 1'b0};
                scroll_layer = SCROLL_OHE[i];
                scroll_pixel = scroll_px[i];
            end
        end
    end

    // sprite wins on a strictly higher score
    always_comb begin
        if (sprite_opaque && (sprite_score > scroll_score)) begin
            layer_next = LAYER_SPRITES_OHE;
            pixel_next = sprite_r;
            score_next = sprite_score;
        end else begin
            layer_next = scroll_layer;
            pixel_next = scroll_pixel;
            score_next = scroll_score;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage2_valid <= 1'b0;
        end else begin
            stage2_valid <= stage1_valid;
        end
    end

    always_ff @(posedge clk) begin
        prio_layer <= layer_next;
        prio_pixel <= pixel_next;
        prio_score <= score_next;
    end

endmodule

// File: verilog/vdp_layer_mask_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vdp layer mask stage
// registers the layer pixels and flags each layer
// that is enabled and opaque at this pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module vdp_layer_mask_gen
    import vdp_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,

    input  logic               pixel_valid,
    input  logic [LAYER_W-1:0] layer_enable,
    input  logic [PIXEL_W-1:0] scroll0_pixel,
    input  logic [PIXEL_W-1:0] scroll1_pixel,
    input  logic [PIXEL_W-1:0] scroll2_pixel,
    input  logic [PIXEL_W-1:0] scroll3_pixel,
    input  logic [PIXEL_W-1:0] sprite_pixel,
    input  logic [1:0]         sprite_priority,

    output logic               stage1_valid,
    output logic [LAYER_W-1:0] layer_mask,
    output logic [PIXEL_W-1:0] scroll0_r,
    output logic [PIXEL_W-1:0] scroll1_r,
    output logic [PIXEL_W-1:0] scroll2_r,
    output logic [PIXEL_W-1:0] scroll3_r,
    output logic [PIXEL_W-1:0] sprite_r,
    output logic [1:0]         sprite_priority_r
);

    logic [PIXEL_W-1:0] scroll_in [NUM_SCROLL];
    logic [LAYER_W-1:0] mask_next;

    assign scroll_in[LAYER_SCROLL0] = scroll0_pixel;
    assign scroll_in[LAYER_SCROLL1] = scroll1_pixel;
    assign scroll_in[LAYER_SCROLL2] = scroll2_pixel;
    assign scroll_in[LAYER_SCROLL3] = scroll3_pixel;

    // colour 0 of every 16-colour sub-palette is see-through
    always_comb begin
        for (int i = 0; i < NUM_SCROLL; i++) begin
            mask_next[LAYER_SCROLL0 + i] = layer_enable[LAYER_SCROLL0 + i] &&
                                           (scroll_in[i][3:0] != 4'd0);
        end
        mask_next[LAYER_SPRITES] = layer_enable[LAYER_SPRITES] && (sprite_pixel[3:0] != 4'd0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= pixel_valid;
        end
    end

    // pixel payload travels without reset
    always_ff @(posedge clk) begin
        layer_mask        <= mask_next;
        scroll0_r         <= scroll0_pixel;
        scroll1_r         <= scroll1_pixel;
        scroll2_r         <= scroll2_pixel;
        scroll3_r         <= scroll3_pixel;
        sprite_r          <= sprite_pixel;
        sprite_priority_r <= sprite_priority;
    end

endmodule

// File: verilog/vdp_host_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vdp host register slave
// Wishbone classic slave with a registered ack, holds
// the layer enable register and issues palette writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module vdp_host_regs
    import vdp_pkg::*;
#(
    parameter int COLOR_W = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Wishbone classic slave
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [WB_ADR_W-1:0]    wb_adr,
    input  logic [COLOR_W-1:0]     wb_dat_w,
    output logic [COLOR_W-1:0]     wb_dat_r,
    output logic                   wb_ack,

    output logic [LAYER_W-1:0]     layer_enable,

    // palette write port
    output logic                   pal_we,
    output logic [PALETTE_SEL-1:0] pal_addr,
    output logic [COLOR_W-1:0]     pal_data
);

    logic req;
    logic reg_sel;

    // a new access is one that has not been acknowledged yet,
    // so each strobe is served exactly once
    assign req = wb_cyc && wb_stb && !wb_ack;

    // full address compare, the palette half never aliases the register
    assign reg_sel = (wb_adr == WB_ADR_W'(REG_LAYER_ENABLE));

    // palette write lands on the same edge that raises wb_ack
    assign pal_we   = req && wb_we && wb_adr[PALETTE_SEL];
    assign pal_addr = wb_adr[PALETTE_SEL-1:0];
    assign pal_data = wb_dat_w;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack       <= 1'b0;
            layer_enable <= LAYER_ENABLE_RESET;
        end else begin
            wb_ack <= req;
            if (req && wb_we && reg_sel) begin
                layer_enable <= wb_dat_w[LAYER_W-1:0];
            end
        end
    end

    // read data is captured with the ack
    // palette is write only, unmapped reads give zero
    always_ff @(posedge clk) begin
        if (req) begin
            if (!wb_we && reg_sel) begin
                wb_dat_r <= COLOR_W'(layer_enable);
            end else begin
                wb_dat_r <= '0;
            end
        end
    end

endmodule

// File: verilog/vdp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vdp compositor shared definitions
// layer positions, one-hot layer codes, widths and
// the host register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package vdp_pkg;

    // number of tile scroll layers in front of the backdrop
    localparam int NUM_SCROLL = 4;

    // bit positions in the layer mask and the one-hot layer code
    localparam int LAYER_SCROLL0 = 0;
    localparam int LAYER_SCROLL1 = 1;
    localparam int LAYER_SCROLL2 = 2;
    localparam int LAYER_SCROLL3 = 3;
    localparam int LAYER_SPRITES = 4;

    localparam int LAYER_W = 5;

    // one-hot layer codes, zero means backdrop
    localparam logic [LAYER_W-1:0] LAYER_SCROLL0_OHE = LAYER_W'(1) << LAYER_SCROLL0;
    localparam logic [LAYER_W-1:0] LAYER_SCROLL1_OHE = LAYER_W'(1) << LAYER_SCROLL1;
    localparam logic [LAYER_W-1:0] LAYER_SCROLL2_OHE = LAYER_W'(1) << LAYER_SCROLL2;
    localparam logic [LAYER_W-1:0] LAYER_SCROLL3_OHE = LAYER_W'(1) << LAYER_SCROLL3;
    localparam logic [LAYER_W-1:0] LAYER_SPRITES_OHE = LAYER_W'(1) << LAYER_SPRITES;

    // resolved priority score
    // scroll layers are even, sprites are odd
    localparam int SCORE_W = 3;

    // palette index width
    localparam int PIXEL_W = 8;

    // host address map
    localparam int WB_ADR_W = 9;
    // high half of the address space is the palette
    localparam int PALETTE_SEL = 8;
    localparam int REG_LAYER_ENABLE = 0;

    // every layer visible out of reset
    localparam logic [LAYER_W-1:0] LAYER_ENABLE_RESET = '1;

endpackage
